//--- verilog/hqm_mem_pkg.sv
// Geometry and data types of the queue-entry data store

package hqm_mem_pkg;

    // --------------------
    // Geometry
    // --------------------

    // Number of entries in the store
    localparam int MEM_DEPTH = 512;

    // Address width needed to reach every entry
    localparam int MEM_AW = 9;

    // Width of the word as seen by the queue logic
    localparam int MEM_DW = 15;

    // Width of one row of the physical array, the top bit is a pad
    localparam int PHY_DW = 16;

    // --------------------
    // Data types
    // --------------------

    // Entry index on both ports
    typedef logic [MEM_AW-1:0] mem_addr_t;

    // Logical word, what the client writes and reads
    typedef logic [MEM_DW-1:0] mem_data_t;

    // Physical row, the logical word plus the zero pad bit
    typedef logic [PHY_DW-1:0] phy_data_t;

endpackage

//--- verilog/hqm_pwr_pkg.sv
// Power-gating states, timing and control bundle for the memory

package hqm_pwr_pkg;

    // Rclk cycles from the array power-enable input to its output
    localparam int PWR_CHAIN_DLY = 4;

    // Depth of the IP reset synchronizer
    localparam int RST_SYNC_STAGES = 2;

    // Cycles the sequencer holds isolation after IP reset release
    localparam int REL_WAIT = RST_SYNC_STAGES + 1;

    // Width of the reset-release wait counter
    localparam int REL_CNT_W = $clog2(REL_WAIT + 1);

    typedef logic [REL_CNT_W-1:0] rel_cnt_t;

    // Sequencer states, in the order a sleep and wake cycle visits them
    typedef enum logic [2:0] {
        ACTIVE,
        ISOLATE,
        PWR_DOWN,
        OFF,
        PWR_UP,
        RESET_REL
    } pwr_state_t;

    // Controls from the sequencer to the memory wrapper
    typedef struct packed {
        logic isol_en;
        logic pwr_enable_b;
        logic ip_reset_b;
    } pwr_ctl_t;

endpackage

//--- verilog/hqm_mem_reset_sync_scan.sv
`timescale 1ns/1ps

// Reset synchronizer for the array IP reset
module hqm_mem_reset_sync_scan (
     input  logic clk
    ,input  logic rst_n
    ,input  logic fscan_rstbypen
    ,input  logic fscan_byprst_b
    ,output logic rst_n_sync
);

    // Shift register that carries the release edge into the clk domain
    logic [hqm_pwr_pkg::RST_SYNC_STAGES-1:0] sync_q;

    // --------------------
    // Synchronizer
    // --------------------

    // Assertion is immediate, release waits for RST_SYNC_STAGES edges
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[hqm_pwr_pkg::RST_SYNC_STAGES-2:0], 1'b1};
        end
    end

    // In scan the tester owns the reset directly
    assign rst_n_sync = fscan_rstbypen ? fscan_byprst_b
                                       : sync_q[hqm_pwr_pkg::RST_SYNC_STAGES-1];

    // --------------------
    // Checks
    // --------------------

    // A release only follows a source reset that was high on the edges before it
    a_no_early_release: assert property (
        @(posedge clk) disable iff (fscan_rstbypen)
        $rose(rst_n_sync) |-> (rst_n && $past(rst_n))
    ) else $error("rst_n_sync released while rst_n was low");

endmodule

//--- verilog/hqm_rf_array_512x16.sv
`timescale 1ns/1ps

// Behavioral two-port 512x16 register file with power gating
module hqm_rf_array_512x16 (
     input  logic                   wclk
    ,input  logic                   we
    ,input  hqm_mem_pkg::mem_addr_t waddr
    ,input  hqm_mem_pkg::phy_data_t wdata
    ,input  logic                   rclk
    ,input  logic                   re
    ,input  hqm_mem_pkg::mem_addr_t raddr
    ,output hqm_mem_pkg::phy_data_t rdata
    ,input  logic                   ip_reset_b
    ,input  logic                   isol_en
    ,input  logic                   pwr_enable_b_in
    ,output logic                   pwr_enable_b_out
    ,input  logic                   fscan_clkungate
);

    // Row storage, contents only mean something where the valid bit is set
    hqm_mem_pkg::phy_data_t mem [hqm_mem_pkg::MEM_DEPTH];

    // One valid bit per row, lost with the supply
    logic [hqm_mem_pkg::MEM_DEPTH-1:0] valid_q;

    hqm_mem_pkg::phy_data_t rdata_q;
    hqm_mem_pkg::phy_data_t rd_word;

    logic we_ok;
    logic re_ok;
    logic rd_cken;

    // Power-enable delay line, one flop per chain segment
    logic [hqm_pwr_pkg::PWR_CHAIN_DLY-1:0] pwr_chain_q;

    // Accesses only land while powered and out of IP reset
    assign we_ok = we && ip_reset_b && !pwr_enable_b_in;
    assign re_ok = re && !pwr_enable_b_in;

    // Scan ungates the read clock so the output latch captures every cycle
    assign rd_cken = re_ok || (fscan_clkungate && !pwr_enable_b_in);

    // --------------------
    // Write port
    // --------------------

    always_ff @(posedge wclk) begin
        if (we_ok) begin
            mem[waddr] <= wdata;
        end
    end

    // Supply off wipes every row, a write revives only its own row
    always_ff @(posedge wclk or negedge ip_reset_b) begin
        if (!ip_reset_b) begin
            valid_q <= '0;
        end else if (pwr_enable_b_in) begin
            valid_q <= '0;
        end else if (we_ok) begin
            valid_q[waddr] <= 1'b1;
        end
    end

    // --------------------
    // Read port
    // --------------------

    // Rows never written since power-up read as zero
    assign rd_word = valid_q[raddr] ? mem[raddr] : '0;

    always_ff @(posedge rclk or negedge ip_reset_b) begin
        if (!ip_reset_b) begin
            rdata_q <= '0;
        end else if (rd_cken) begin
            rdata_q <= rd_word;
        end
    end

    // Isolation clamps the output low while the macro may be floating
    assign rdata = isol_en ? '0 : rdata_q;

    // --------------------
    // Power chain
    // --------------------

    // The chain follows its input level and settles within PWR_CHAIN_DLY cycles
    always_ff @(posedge rclk) begin
        pwr_chain_q <= {pwr_chain_q[hqm_pwr_pkg::PWR_CHAIN_DLY-2:0], pwr_enable_b_in};
    end

    assign pwr_enable_b_out = pwr_chain_q[hqm_pwr_pkg::PWR_CHAIN_DLY-1];

    // --------------------
    // Checks
    // --------------------

    // A write attempted with the supply off leaves the stored row untouched
    a_no_write_off: assert property (
        @(posedge wclk) (we && pwr_enable_b_in) |=> (mem[$past(waddr)] === $past(mem[waddr]))
    ) else $error("write landed while pwr_enable_b_in was high");

    // A read attempted with the supply off leaves the output latch alone
    a_no_read_off: assert property (
        @(posedge rclk) (re && pwr_enable_b_in) |=> $stable(rdata_q)
    ) else $error("read landed while pwr_enable_b_in was high");

    // Addresses must be known and inside the array on every access
    a_waddr_range: assert property (
        @(posedge wclk) we |-> (!$isunknown(waddr) && (int'(waddr) < hqm_mem_pkg::MEM_DEPTH))
    ) else $error("waddr out of range");

    a_raddr_range: assert property (
        @(posedge rclk) re |-> (!$isunknown(raddr) && (int'(raddr) < hqm_mem_pkg::MEM_DEPTH))
    ) else $error("raddr out of range");

endmodule

//--- verilog/hqm_qed_mem_AW_rf_pg_512x15.sv
`timescale 1ns/1ps

// Queue-entry data store, 512 words of 15 bits on a 16-bit power-gated array
module hqm_qed_mem_AW_rf_pg_512x15 (
     input  logic                   wclk
    ,input  logic                   wclk_rst_n
    ,input  logic                   we
    ,input  hqm_mem_pkg::mem_addr_t waddr
    ,input  hqm_mem_pkg::mem_data_t wdata

    ,input  logic                   rclk
    ,input  logic                   rclk_rst_n
    ,input  logic                   re
    ,input  hqm_mem_pkg::mem_addr_t raddr

    ,output hqm_mem_pkg::mem_data_t rdata

    // Power interface
    ,input  hqm_pwr_pkg::pwr_ctl_t  pwr_ctl
    ,output logic                   pwr_enable_b_out

    // Scan controls
    ,input  logic                   fscan_byprst_b
    ,input  logic                   fscan_clkungate
    ,input  logic                   fscan_rstbypen
);

    hqm_mem_pkg::phy_data_t wdata_phy;
    hqm_mem_pkg::phy_data_t rdata_phy;

    // Source of the synchronizer, functional reset or sequencer request
    logic ip_reset_b_src;
    logic ip_reset_b_sync;

    // Reset seen by the array on both ports
    logic array_rst_b;

    // --------------------
    // IP reset
    // --------------------

    // A domain reset also restarts the synchronizer so release is clean
    assign ip_reset_b_src = pwr_ctl.ip_reset_b && rclk_rst_n;

    hqm_mem_reset_sync_scan i_ip_reset_b_sync (
         .clk            (rclk)
        ,.rst_n          (ip_reset_b_src)
        ,.fscan_rstbypen (fscan_rstbypen)
        ,.fscan_byprst_b (fscan_byprst_b)
        ,.rst_n_sync     (ip_reset_b_sync)
    )

    ;

    // Either port reset holds the whole array
    assign array_rst_b = ip_reset_b_sync && wclk_rst_n && rclk_rst_n;

    // --------------------
    // Array
    // --------------------

    // Pad the spare top bit with zero
    assign wdata_phy = {{(hqm_mem_pkg::PHY_DW - hqm_mem_pkg::MEM_DW){1'b0}}, wdata};

    hqm_rf_array_512x16 i_rf (
         .wclk             (wclk)
        ,.we               (we)
        ,.waddr            (waddr)
        ,.wdata            (wdata_phy)
        ,.rclk             (rclk)
        ,.re               (re)
        ,.raddr            (raddr)
        ,.rdata            (rdata_phy)
        ,.ip_reset_b       (array_rst_b)
        ,.isol_en          (pwr_ctl.isol_en)
        ,.pwr_enable_b_in  (pwr_ctl.pwr_enable_b)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.fscan_clkungate  (fscan_clkungate)
    );

    // Pad bit is dropped on the way out
    assign rdata = rdata_phy[hqm_mem_pkg::MEM_DW-1:0];

endmodule

//--- verilog/hqm_mem_pwr_ctl.sv
`timescale 1ns/1ps

// Power-gate sequencer for the data store
module hqm_mem_pwr_ctl (
     input  logic                  rclk
    ,input  logic                  rst_n
    ,input  logic                  sleep_req
    ,input  logic                  pwr_enable_b_out
    ,output hqm_pwr_pkg::pwr_ctl_t pwr_ctl
    ,output logic                  mem_ready
);

    hqm_pwr_pkg::pwr_state_t state_q;
    hqm_pwr_pkg::pwr_state_t state_nxt;

    // Counts down the reset-release wait, also used once after reset
    hqm_pwr_pkg::rel_cnt_t cnt_q;
    hqm_pwr_pkg::rel_cnt_t cnt_nxt;

    // --------------------
    // State register
    // --------------------

    // Out of reset the array is still in synchronizer reset for a few cycles
    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= hqm_pwr_pkg::ACTIVE;
            cnt_q   <= hqm_pwr_pkg::rel_cnt_t'(hqm_pwr_pkg::RST_SYNC_STAGES);
        end else begin
            state_q <= state_nxt;
            cnt_q   <= cnt_nxt;
        end
    end

    // --------------------
    // Next state
    // --------------------

    always_comb begin
        state_nxt = state_q;
        cnt_nxt   = cnt_q;
        case (state_q)
            hqm_pwr_pkg::ACTIVE: begin
                if (cnt_q != '0) begin
                    cnt_nxt = cnt_q - hqm_pwr_pkg::rel_cnt_t'(1);
                end
                if (sleep_req) begin
                    state_nxt = hqm_pwr_pkg::ISOLATE;
                    cnt_nxt   = '0;
                end
            end
            // One cycle of clamp before the supply goes
            hqm_pwr_pkg::ISOLATE: begin
                state_nxt = hqm_pwr_pkg::PWR_DOWN;
            end
            // Wait for the far end of the power chain
            hqm_pwr_pkg::PWR_DOWN: begin
                if (pwr_enable_b_out) begin
                    state_nxt = hqm_pwr_pkg::OFF;
                end
            end
            hqm_pwr_pkg::OFF: begin
                if (!sleep_req) begin
                    state_nxt = hqm_pwr_pkg::PWR_UP;
                end
            end
            hqm_pwr_pkg::PWR_UP: begin
                if (!pwr_enable_b_out) begin
                    state_nxt = hqm_pwr_pkg::RESET_REL;
                    cnt_nxt   = hqm_pwr_pkg::rel_cnt_t'(hqm_pwr_pkg::REL_WAIT);
                end
            end
            // Synchronizer needs RST_SYNC_STAGES edges, plus one of margin
            hqm_pwr_pkg::RESET_REL: begin
                if (cnt_q == hqm_pwr_pkg::rel_cnt_t'(1)) begin
                    state_nxt = hqm_pwr_pkg::ACTIVE;
                    cnt_nxt   = '0;
                end else begin
                    cnt_nxt = cnt_q - hqm_pwr_pkg::rel_cnt_t'(1);
                end
            end
            default: begin
                state_nxt = hqm_pwr_pkg::ACTIVE;
            end
        endcase
    end

    // --------------------
    // Outputs
    // --------------------

    // Controls are a pure decode of the state
    always_comb begin
        pwr_ctl.isol_en      = (state_q != hqm_pwr_pkg::ACTIVE);
        pwr_ctl.pwr_enable_b = (state_q == hqm_pwr_pkg::PWR_DOWN) ||
                               (state_q == hqm_pwr_pkg::OFF);
        pwr_ctl.ip_reset_b   = (state_q == hqm_pwr_pkg::ACTIVE)  ||
                               (state_q == hqm_pwr_pkg::ISOLATE) ||
                               (state_q == hqm_pwr_pkg::RESET_REL);
    end

    assign mem_ready = (state_q == hqm_pwr_pkg::ACTIVE) && (cnt_q == '0);

    // Output stays clamped as long as any part of the chain is unpowered
    a_isol_covers_pwr: assert property (
        @(posedge rclk) disable iff (!rst_n)
        (pwr_ctl.pwr_enable_b || pwr_enable_b_out) |-> pwr_ctl.isol_en
    ) else $error("memory powered down without isolation");

endmodule

//--- verilog/hqm_qed_mem_sub.sv
`timescale 1ns/1ps

// Data store subsystem, sequencer plus power-gated memory
module hqm_qed_mem_sub (
     input  logic                   wclk
    ,input  logic                   rclk
    ,input  logic                   rst_n

    // Write port
    ,input  logic                   we
    ,input  hqm_mem_pkg::mem_addr_t waddr
    ,input  hqm_mem_pkg::mem_data_t wdata

    // Read port
    ,input  logic                   re
    ,input  hqm_mem_pkg::mem_addr_t raddr
    ,output hqm_mem_pkg::mem_data_t rdata

    // Power management
    ,input  logic                   sleep_req
    ,output logic                   mem_ready

    // Scan controls
    ,input  logic                   fscan_byprst_b
    ,input  logic                   fscan_clkungate
    ,input  logic                   fscan_rstbypen
);

    // Sequencer controls toward the memory
    hqm_pwr_pkg::pwr_ctl_t pwr_ctl;

    // Far end of the array power chain, back to the sequencer
    logic pwr_enable_b_out;

    // --------------------
    // Sequencer
    // --------------------

    // Runs in the read domain, where the power chain and reset sync live
    hqm_mem_pwr_ctl i_pwr_ctl (
         .rclk             (rclk)
        ,.rst_n            (rst_n)
        ,.sleep_req        (sleep_req)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.pwr_ctl          (pwr_ctl)
        ,.mem_ready        (mem_ready)
    );

    // --------------------
    // Memory
    // --------------------

    // One system reset serves both port domains
    hqm_qed_mem_AW_rf_pg_512x15 i_mem (
         .wclk             (wclk)
        ,.wclk_rst_n       (rst_n)
        ,.we               (we)
        ,.waddr            (waddr)
        ,.wdata            (wdata)
        ,.rclk             (rclk)
        ,.rclk_rst_n       (rst_n)
        ,.re               (re)
        ,.raddr            (raddr)
        ,.rdata            (rdata)
        ,.pwr_ctl          (pwr_ctl)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.fscan_byprst_b   (fscan_byprst_b)
        ,.fscan_clkungate  (fscan_clkungate)
        ,.fscan_rstbypen   (fscan_rstbypen)
    );

endmodule

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ps

// Clock and power-on reset for the data store testbench
module tb_clk_gen (
     output logic clk
    ,output logic rst_n
);

    // Half of the 8 ns clock period
    localparam int HALF_PERIOD = 4;

    // Cycles that rst_n is held low after time zero
    localparam int RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // Release lands on a rising edge like any other driven input
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- tests/tb_hqm_qed_mem_sub.sv
`timescale 1ns/1ps

// Table-driven testbench for the power-gated data store subsystem
module tb_hqm_qed_mem_sub;

    // Worst-case cycles that one table row may take
    localparam int ROW_WORST_CYCLES = 40;

    // Cycles allowed for mem_ready to reach a level
    localparam int READY_LIMIT = 30;

    typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,
        OP_SLEEP,
        OP_WAKE,
        OP_WAIT_READY
    } op_e;

    // One table row, stimulus plus what the DUT must show afterwards
    typedef struct packed {
        op_e                    op;
        hqm_mem_pkg::mem_addr_t addr;
        hqm_mem_pkg::mem_data_t data;
        hqm_mem_pkg::mem_data_t exp_data;
        logic                   exp_ready;
        logic [3:0]             test_id;
    } row_t;

    logic                   clk;
    logic                   rst_n;
    logic                   we;
    hqm_mem_pkg::mem_addr_t waddr;
    hqm_mem_pkg::mem_data_t wdata;
    logic                   re;
    hqm_mem_pkg::mem_addr_t raddr;
    hqm_mem_pkg::mem_data_t rdata;
    logic                   sleep_req;
    logic                   mem_ready;
    logic                   fscan_byprst_b;
    logic                   fscan_clkungate;
    logic                   fscan_rstbypen;

    row_t rows [$];

    // Reference model of the store, as the client should see it
    logic                   model_valid [hqm_mem_pkg::MEM_DEPTH];
    hqm_mem_pkg::mem_data_t model_data [hqm_mem_pkg::MEM_DEPTH];
    hqm_mem_pkg::mem_addr_t written_q [$];
    bit                     model_asleep;
    logic [3:0]             build_test;
    bit                     table_built;

    // Read in flight and the value rdata must hold between reads
    bit                     pend_valid;
    hqm_mem_pkg::mem_addr_t pend_addr;
    hqm_mem_pkg::mem_data_t pend_exp;
    hqm_mem_pkg::mem_data_t hold_exp;

    int test_errors;
    int total_errors;
    int tests_run;
    int tests_failed;
    int checks;
    int unsigned seed;
    logic [3:0] cur_test;

    tb_clk_gen clk_gen0 (
         .clk   (clk)
        ,.rst_n (rst_n)
    );

    // Both port clocks come from the same generator
    hqm_qed_mem_sub dut0 (
         .wclk            (clk)
        ,.rclk            (clk)
        ,.rst_n           (rst_n)
        ,.we              (we)
        ,.waddr           (waddr)
        ,.wdata           (wdata)
        ,.re              (re)
        ,.raddr           (raddr)
        ,.rdata           (rdata)
        ,.sleep_req       (sleep_req)
        ,.mem_ready       (mem_ready)
        ,.fscan_byprst_b  (fscan_byprst_b)
        ,.fscan_clkungate (fscan_clkungate)
        ,.fscan_rstbypen  (fscan_rstbypen)
    );

    // --------------------
    // Table building
    // --------------------

    function automatic void add_row(input op_e op, input hqm_mem_pkg::mem_addr_t addr,
                                    input hqm_mem_pkg::mem_data_t data,
                                    input hqm_mem_pkg::mem_data_t exp_data);
        row_t r;
        r.op        = op;
        r.addr      = addr;
        r.data      = data;
        r.exp_data  = exp_data;
        r.exp_ready = !model_asleep;
        r.test_id   = build_test;
        rows.push_back(r);
    endfunction

    // Invalid rows and an isolated output both read as zero
    function automatic hqm_mem_pkg::mem_data_t model_peek(input hqm_mem_pkg::mem_addr_t addr);
        if (model_asleep || !model_valid[addr]) begin
            return '0;
        end
        return model_data[addr];
    endfunction

    // A write while the store is down is dropped
    function automatic void add_write(input hqm_mem_pkg::mem_addr_t addr,
                                      input hqm_mem_pkg::mem_data_t data);
        if (!model_asleep) begin
            model_valid[addr] = 1'b1;
            model_data[addr]  = data;
            written_q.push_back(addr);
        end
        add_row(OP_WRITE, addr, data, '0);
    endfunction

    function automatic void add_read(input hqm_mem_pkg::mem_addr_t addr);
        add_row(OP_READ, addr, '0, model_peek(addr));
    endfunction

    // Power-off loses every row
    function automatic void add_sleep();
        model_asleep = 1'b1;
        foreach (model_valid[i]) begin
            model_valid[i] = 1'b0;
        end
        add_row(OP_SLEEP, '0, '0, '0);
    endfunction

    function automatic void add_wake();
        model_asleep = 1'b0;
        add_row(OP_WAKE, '0, '0, '0);
    endfunction

    function automatic void build_table();
        hqm_mem_pkg::mem_addr_t addr;
        hqm_mem_pkg::mem_data_t data;
        hqm_mem_pkg::mem_addr_t rand_q [$];

        model_asleep = 1'b0;
        foreach (model_valid[i]) begin
            model_valid[i] = 1'b0;
        end

        // Out of reset every row is invalid
        build_test = 4'd1;
        add_row(OP_WAIT_READY, '0, '0, '0);
        add_row(OP_READ, 9'h000, '0, 15'h0000);
        add_row(OP_READ, 9'h1ff, '0, 15'h0000);
        add_row(OP_READ, 9'h0a5, '0, 15'h0000);

        // Directed write and read, then reads on consecutive cycles
        build_test = 4'd2;
        add_write(9'h005, 15'h1234);
        add_row(OP_READ, 9'h005, '0, 15'h1234);
        add_write(9'h006, 15'h0abc);
        add_write(9'h007, 15'h5a5a);
        add_row(OP_READ, 9'h006, '0, 15'h0abc);
        add_row(OP_READ, 9'h007, '0, 15'h5a5a);
        add_row(OP_READ, 9'h005, '0, 15'h1234);

        // All-ones words at both ends of the range, then random traffic
        build_test = 4'd3;
        add_write(9'h000, 15'h7fff);
        add_write(9'h1ff, 15'h7fff);
        for (int i = 0; i < 20; i++) begin
            addr = hqm_mem_pkg::mem_addr_t'($urandom);
            data = hqm_mem_pkg::mem_data_t'($urandom);
            add_write(addr, data);
            rand_q.push_back(addr);
        end
        add_read(9'h000);
        add_read(9'h1ff);
        foreach (rand_q[i]) begin
            add_read(rand_q[i]);
        end
        for (int i = 0; i < 4; i++) begin
            add_read(hqm_mem_pkg::mem_addr_t'($urandom));
        end

        // rdata keeps the last read while the row underneath changes
        build_test = 4'd4;
        add_read(9'h006);
        add_write(9'h006, 15'h1111);
        add_write(9'h008, 15'h2222);
        add_read(9'h006);
        add_read(9'h008);

        // Sleep clamps the output, wake finds every row lost
        build_test = 4'd5;
        add_sleep();
        add_read(9'h005);
        add_wake();
        foreach (written_q[i]) begin
            add_read(written_q[i]);
        end
        written_q.delete();

        // Traffic while down is dropped, the store works again after wake
        build_test = 4'd6;
        add_sleep();
        add_write(9'h010, 15'h3333);
        add_write(9'h011, 15'h7fff);
        add_read(9'h010);
        add_wake();
        add_read(9'h010);
        add_read(9'h011);
        add_write(9'h010, 15'h4444);
        add_read(9'h010);
    endfunction

    // --------------------
    // Checks
    // --------------------

    // Checks the read that landed on the last edge, or that rdata held
    task automatic settle_check();
        checks++;
        if (pend_valid) begin
            assert (rdata === pend_exp) else begin
                $display("MISMATCH at %0t: read of 0x%03h returned 0x%04h, expected 0x%04h",
                         $time, pend_addr, rdata, pend_exp);
                test_errors++;
            end
            hold_exp   = pend_exp;
            pend_valid = 1'b0;
        end else begin
            assert (rdata === hold_exp) else begin
                $display("MISMATCH at %0t: rdata is 0x%04h without a read, expected 0x%04h",
                         $time, rdata, hold_exp);
                test_errors++;
            end
        end
    endtask

    task automatic check_ready(input logic exp_ready);
        checks++;
        assert (mem_ready === exp_ready) else begin
            $display("MISMATCH at %0t: mem_ready is %0b, expected %0b",
                     $time, mem_ready, exp_ready);
            test_errors++;
        end
    endtask

    task automatic wait_ready_level(input logic level);
        int n;
        bit seen;
        seen = 1'b0;
        for (n = 0; (n < READY_LIMIT) && !seen; n++) begin
            @(negedge clk);
            if (mem_ready === level) begin
                seen = 1'b1;
            end
        end
        assert (seen) else begin
            $display("Timed out at %0t waiting for mem_ready to become %0b", $time, level);
            test_errors++;
        end
    endtask

    // --------------------
    // Row execution
    // --------------------

    task automatic apply_row(input row_t r);
        @(posedge clk);
        we    <= (r.op == OP_WRITE);
        re    <= (r.op == OP_READ);
        waddr <= r.addr;
        wdata <= r.data;
        raddr <= r.addr;
        if (r.op == OP_SLEEP) begin
            sleep_req <= 1'b1;
        end
        if (r.op == OP_WAKE) begin
            sleep_req <= 1'b0;
        end
        @(negedge clk);
        settle_check();
        case (r.op)
            OP_READ: begin
                pend_valid = 1'b1;
                pend_addr  = r.addr;
                pend_exp   = r.exp_data;
            end
            // In ISOLATE the clamp alone hides the last read, then two
            // more cycles put the sequencer into power-down
            OP_SLEEP: begin
                wait_ready_level(1'b0);
                hold_exp = '0;
                settle_check();
                repeat (2) @(negedge clk);
                settle_check();
            end
            OP_WAKE, OP_WAIT_READY: begin
                wait_ready_level(1'b1);
                settle_check();
            end
            default: begin
            end
        endcase
        check_ready(r.exp_ready);
    endtask

    // One idle cycle settles the last read before the test is scored
    task automatic close_test(input logic [3:0] id);
        @(posedge clk);
        we <= 1'b0;
        re <= 1'b0;
        @(negedge clk);
        settle_check();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d: pass", id);
        end else begin
            $display("test %0d: fail with %0d errors", id, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        seed = 32'hafc1;
        void'($urandom(seed));
        we              = 1'b0;
        waddr           = '0;
        wdata           = '0;
        re              = 1'b0;
        raddr           = '0;
        sleep_req       = 1'b0;
        fscan_byprst_b  = 1'b1;
        fscan_clkungate = 1'b0;
        fscan_rstbypen  = 1'b0;
        pend_valid      = 1'b0;
        pend_addr       = '0;
        pend_exp        = '0;
        hold_exp        = '0;
        test_errors     = 0;
        total_errors    = 0;
        tests_run       = 0;
        tests_failed    = 0;
        checks          = 0;
        build_table();
        table_built = 1'b1;

        wait (rst_n === 1'b1);
        cur_test = rows[0].test_id;
        foreach (rows[i]) begin
            if (rows[i].test_id != cur_test) begin
                close_test(cur_test);
                cur_test = rows[i].test_id;
            end
            apply_row(rows[i]);
        end
        close_test(cur_test);

        $display("%0d tests, %0d passed, %0d failed, %0d rows, %0d checks, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, rows.size(), checks,
                 total_errors);
        if (total_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Bound on the whole run, from the table length and the worst row
    initial begin
        wait (table_built);
        repeat (rows.size() * ROW_WORST_CYCLES + 20) @(posedge clk);
        $display("Watchdog expired at %0t before the table finished", $time);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- sim.f
verilog/hqm_mem_pkg.sv
verilog/hqm_pwr_pkg.sv
verilog/hqm_mem_reset_sync_scan.sv
verilog/hqm_rf_array_512x16.sv
verilog/hqm_qed_mem_AW_rf_pg_512x15.sv
verilog/hqm_mem_pwr_ctl.sv
verilog/hqm_qed_mem_sub.sv
tests/tb_clk_gen.sv
tests/tb_hqm_qed_mem_sub.sv

//--- Makefile
# Verilator build, run and lint for the data store subsystem

VERILATOR  ?= verilator
FILE_LIST  ?= sim.f
TB_TOP     ?= tb_hqm_qed_mem_sub
RTL_TOP    ?= hqm_qed_mem_sub
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only
PASS_TEXT  ?= ALL TESTS PASSED

SRC_FILES = $(shell cat $(FILE_LIST))
RTL_FILES = $(shell grep '^verilog/' $(FILE_LIST))
SIM_BIN   = $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILE_LIST) $(SRC_FILES)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

# The run passes only if the testbench printed the pass line
run: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_FILES) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
